/* grom_cpu.f */
hdl/grom_pkg.sv
hdl/grom_regfile.sv
hdl/grom_alu.sv
hdl/grom_control.sv
hdl/grom_cpu.sv
verif/grom_mem_model.sv
verif/grom_cpu_tb.sv

/* hdl/grom_alu.sv */
module grom_alu
	import grom_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    alu_start,
	input  alu_op_t alu_op,
	input  data_t   alu_a,
	input  data_t   alu_b,
	output data_t   alu_result,
	output flags_t  flags
);

	logic [data_w:0] sum;   // Top bit is carry or borrow

	always_comb
	begin
		case (alu_op)
			alu_add: sum = {1'b0, alu_a} + {1'b0, alu_b};
			alu_sub,
			alu_cmp: sum = {1'b0, alu_a} - {1'b0, alu_b};
			alu_and: sum = {1'b0, alu_a & alu_b};
			alu_or:  sum = {1'b0, alu_a | alu_b};
			alu_xor: sum = {1'b0, alu_a ^ alu_b};
			alu_inc: sum = {1'b0, alu_b} + 1'b1;
			alu_dec: sum = {1'b0, alu_b} - 1'b1;
			default: sum = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (alu_start)
			alu_result <= sum[data_w-1:0];
	end

	// Flags persist between operations
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (alu_start)
		begin
			flags.cf <= sum[data_w];
			flags.zf <= (sum[data_w-1:0] == '0);
			flags.sf <= sum[data_w-1];
		end
	end

	a_op_known: assert property (@(posedge clk) disable iff (reset)
		alu_start |-> !$isunknown(alu_op));

endmodule

/* hdl/grom_control.sv */
module grom_control
	import grom_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	output mem_req_t   mem_req,
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	input  logic       mem_rsp_valid,
	input  data_t      mem_rdata,
	output logic       hlt,
	output reg_wr_t    reg_wr,
	output reg_idx_t   rd_idx_a,
	output reg_idx_t   rd_idx_b,
	input  data_t      rd_data_a,
	input  data_t      rd_data_b,
	output logic       ds_wr,
	output data_t      ds_data,
	input  logic [3:0] ds,
	output logic       alu_start,
	output alu_op_t    alu_op,
	output data_t      alu_a,
	output data_t      alu_b,
	input  data_t      alu_result,
	input  flags_t     flags
);

	typedef enum logic [2:0] {
		s_fetch_req, s_fetch_wait, s_decode, s_operand_req,
		s_operand_wait, s_exec_long, s_load_wait, s_alu_wait
	} state_t;

	state_t   state;
	addr_t    pc;
	instr_t   ir;
	data_t    operand;   // Second byte of long instructions
	reg_idx_t dest_idx;
	logic     alu_ok;
	logic     alu_writes;
	logic     jump_taken;

	// ALU operation from the short view
	always_comb
	begin
		alu_ok = 1'b1;
		alu_op = alu_add;
		case (ir.s.op_group)
			op_arith:
				case (ir.s.field_a)
					2'b00:   alu_op = alu_add;
					2'b01:   alu_op = alu_sub;
					default: alu_ok = 1'b0;   // ADC, SBC
				endcase
			op_logic:
				case (ir.s.field_a)
					2'b00:   alu_op = alu_and;
					2'b01:   alu_op = alu_or;
					2'b11:   alu_op = alu_xor;
					default: alu_ok = 1'b0;   // NOT
				endcase
			op_incdec:
				case (ir.s.field_a)
					2'b00:   alu_op = alu_inc;
					2'b01:   alu_op = alu_dec;
					2'b10:   alu_op = alu_cmp;
					default: alu_ok = 1'b0;   // TEST
				endcase
			default: alu_ok = 1'b0;
		endcase
	end

	assign alu_writes = !(ir.s.op_group == op_incdec && ir.s.field_a == 2'b10);

	always_comb
	begin
		case (ir.l.nibble)
			cond_jmp: jump_taken = 1'b1;
			cond_jc:  jump_taken = flags.cf;
			cond_jnc: jump_taken = !flags.cf;
			cond_jm:  jump_taken = flags.sf;
			cond_jp:  jump_taken = !flags.sf;
			cond_jz:  jump_taken = flags.zf;
			cond_jnz: jump_taken = !flags.zf;
			default:  jump_taken = 1'b0;
		endcase
	end

	// Port A is R0 except for the STORE address
	assign rd_idx_a  = (ir.s.op_group == op_store_ind) ? ir.s.field_a : 2'd0;
	assign rd_idx_b  = ir.s.field_b;
	assign alu_start = (state == s_decode) && !ir.l.long_op[3] && alu_ok;
	assign alu_a     = rd_data_a;
	assign alu_b     = rd_data_b;

	always_comb
	begin
		reg_wr  = '0;
		ds_wr   = 1'b0;
		ds_data = rd_data_b;
		case (state)
			s_decode:
				if (ir.s.op_group == op_mov_rr)
					reg_wr = '{en: 1'b1, idx: ir.s.field_a, data: rd_data_b};
				else if (ir.s.op_group == op_special && ir.s.field_a == 2'b01)
					ds_wr = 1'b1;   // MOV DS,Rb
			s_exec_long:
				if (ir.l.long_op == op_ds_imm)
				begin
					ds_wr   = 1'b1;
					ds_data = operand;
				end
				else if (ir.s.op_group == op_imm && ir.s.field_a == 2'b00)
					reg_wr = '{en: 1'b1, idx: ir.s.field_b, data: operand};
			s_load_wait: reg_wr = '{en: mem_rsp_valid, idx: dest_idx, data: mem_rdata};
			s_alu_wait:  reg_wr = '{en: alu_writes, idx: dest_idx, data: alu_result};
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state         <= s_fetch_req;
			pc            <= '0;
			mem_req_valid <= 1'b0;
			hlt           <= 1'b0;
		end
		else
		begin
			if (mem_req_valid && mem_req_ready)
				mem_req_valid <= 1'b0;
			case (state)
				s_fetch_req:
					if (!hlt && !mem_req_valid)   // Also waits out a pending store
					begin
						mem_req       <= '{addr: pc, we: 1'b0, wdata: '0};
						mem_req_valid <= 1'b1;
						state         <= s_fetch_wait;
					end
				s_fetch_wait:
					if (mem_rsp_valid)
					begin
						ir    <= mem_rdata;
						pc    <= pc + 1'b1;
						state <= s_decode;
					end
				s_decode:
				begin
					state <= s_fetch_req;
					if (ir.l.long_op[3])
						state <= s_operand_req;
					else if (alu_ok)
					begin
						dest_idx <= (ir.s.op_group == op_incdec) ? ir.s.field_b : 2'd0;
						state    <= s_alu_wait;
					end
					else
						case (ir.s.op_group)
							op_load_ind:
							begin
								mem_req       <= '{addr: {ds, rd_data_b}, we: 1'b0, wdata: '0};
								mem_req_valid <= 1'b1;
								dest_idx      <= ir.s.field_a;
								state         <= s_load_wait;
							end
							op_store_ind:
							begin
								mem_req       <= '{addr: {ds, rd_data_a}, we: 1'b1, wdata: rd_data_b};
								mem_req_valid <= 1'b1;
							end
							op_special:
								if (ir.s.field_a == 2'b11 && ir.s.field_b == 2'b11)
									hlt <= 1'b1;
							default: ;   // No-op
						endcase
				end
				s_operand_req:
				begin
					mem_req       <= '{addr: pc, we: 1'b0, wdata: '0};
					mem_req_valid <= 1'b1;
					pc            <= pc + 1'b1;
					state         <= s_operand_wait;
				end
				s_operand_wait:
					if (mem_rsp_valid)
					begin
						operand <= mem_rdata;
						state   <= s_exec_long;
					end
				s_exec_long:
				begin
					state <= s_fetch_req;
					case (ir.l.long_op)
						op_jcond:
							if (jump_taken)
								pc <= {pc[addr_w-1:data_w], operand};   // Same page
						op_jump: pc <= {ir.l.nibble, operand};
						op_imm:
							case (ir.s.field_a)
								2'b01:
								begin
									mem_req       <= '{addr: {ds, operand}, we: 1'b0, wdata: '0};
									mem_req_valid <= 1'b1;
									dest_idx      <= ir.s.field_b;
									state         <= s_load_wait;
								end
								2'b10:
								begin
									mem_req       <= '{addr: {ds, operand}, we: 1'b1, wdata: rd_data_b};
									mem_req_valid <= 1'b1;
								end
								default: ;
							endcase
						default: ;
					endcase
				end
				s_load_wait:
					if (mem_rsp_valid)
						state <= s_fetch_req;
				s_alu_wait: state <= s_fetch_req;
				default:    state <= s_fetch_req;
			endcase
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

	a_no_req_halted: assert property (@(posedge clk) disable iff (reset)
		hlt |-> !mem_req_valid);

endmodule

/* hdl/grom_cpu.sv */
module grom_cpu
	import grom_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	output mem_req_t mem_req,
	output logic     mem_req_valid,
	input  logic     mem_req_ready,
	input  logic     mem_rsp_valid,
	input  data_t    mem_rdata,
	output logic     hlt
);

	reg_wr_t    reg_wr;
	reg_idx_t   rd_idx_a;
	reg_idx_t   rd_idx_b;
	data_t      rd_data_a;
	data_t      rd_data_b;
	logic       ds_wr;
	data_t      ds_data;
	logic [3:0] ds;       // Data segment nibble
	logic       alu_start;
	alu_op_t    alu_op;
	data_t      alu_a;
	data_t      alu_b;
	data_t      alu_result;
	flags_t     flags;

	grom_control control_i (
		.clk, .reset,
		.mem_req, .mem_req_valid, .mem_req_ready, .mem_rsp_valid, .mem_rdata,
		.hlt,
		.reg_wr, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
		.ds_wr, .ds_data, .ds,
		.alu_start, .alu_op, .alu_a, .alu_b, .alu_result, .flags
	);

	grom_regfile regfile_i (
		.clk, .reset,
		.reg_wr, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
		.ds_wr, .ds_data, .ds
	);

	grom_alu alu_i (
		.clk, .reset,
		.alu_start, .alu_op, .alu_a, .alu_b, .alu_result, .flags
	);

endmodule

/* hdl/grom_pkg.sv */
package grom_pkg;

	localparam int addr_w = 12;
	localparam int data_w = 8;

	typedef logic [1:0]        reg_idx_t;
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;

	// Opcode groups, upper nibble of the instruction
	localparam logic [3:0] op_mov_rr    = 4'b0000;
	localparam logic [3:0] op_arith     = 4'b0001;
	localparam logic [3:0] op_logic     = 4'b0010;
	localparam logic [3:0] op_incdec    = 4'b0011;
	localparam logic [3:0] op_load_ind  = 4'b0101;
	localparam logic [3:0] op_store_ind = 4'b0110;
	localparam logic [3:0] op_special   = 4'b0111;
	localparam logic [3:0] op_jcond     = 4'b1000;
	localparam logic [3:0] op_jump      = 4'b1001;
	localparam logic [3:0] op_ds_imm    = 4'b1110;
	localparam logic [3:0] op_imm       = 4'b1111;

	// Jump conditions in the low nibble of op_jcond
	localparam logic [3:0] cond_jmp = 4'h0;
	localparam logic [3:0] cond_jc  = 4'h1;
	localparam logic [3:0] cond_jnc = 4'h2;
	localparam logic [3:0] cond_jm  = 4'h3;
	localparam logic [3:0] cond_jp  = 4'h4;
	localparam logic [3:0] cond_jz  = 4'h5;
	localparam logic [3:0] cond_jnz = 4'h6;

	typedef struct packed {
		logic [3:0] op_group;
		reg_idx_t   field_a;
		reg_idx_t   field_b;
	} instr_short_t;

	typedef struct packed {
		logic [3:0] long_op;
		logic [3:0] nibble;
	} instr_long_t;

	typedef union packed {
		instr_short_t s;
		instr_long_t  l;
	} instr_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_inc, alu_dec, alu_cmp
	} alu_op_t;

	typedef struct packed {
		logic cf;
		logic zf;
		logic sf;
	} flags_t;

	typedef struct packed {
		addr_t addr;
		logic  we;
		data_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic     en;
		reg_idx_t idx;
		data_t    data;
	} reg_wr_t;

endpackage

/* hdl/grom_regfile.sv */
module grom_regfile
	import grom_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  reg_wr_t    reg_wr,
	input  reg_idx_t   rd_idx_a,
	input  reg_idx_t   rd_idx_b,
	output data_t      rd_data_a,
	output data_t      rd_data_b,
	input  logic       ds_wr,
	input  data_t      ds_data,
	output logic [3:0] ds
);

	data_t r [4];   // R0 to R3

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			r  <= '{default: '0};
			ds <= 4'h0;
		end
		else
		begin
			if (reg_wr.en)
				r[reg_wr.idx] <= reg_wr.data;
			if (ds_wr)
				ds <= ds_data[3:0];
		end
	end

	assign rd_data_a = r[rd_idx_a];
	assign rd_data_b = r[rd_idx_b];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the grom_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert \
	--top-module grom_cpu_tb \
	-f grom_cpu.f \
	-Mdir "$build_dir" -o grom_cpu_sim; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/grom_cpu_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ "$run_status" -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
	echo "FAIL"
	exit 1
fi
echo "PASS"
exit 0

/* verif/grom_cpu_tb.sv */
module grom_cpu_tb
	import grom_pkg::*;
();

	localparam int clk_period   = 10;
	localparam int reset_cycles = 10;
	localparam int max_cycles   = 4000;   // Program needs a few hundred cycles even with stalls
	localparam int drain_cycles = 20;

	logic     clk;
	logic     reset;
	mem_req_t mem_req;
	logic     mem_req_valid;
	logic     mem_req_ready;
	logic     mem_rsp_valid;
	data_t    mem_rdata;
	logic     hlt;
	logic     store_valid;
	data_t    store_idx;
	addr_t    store_addr;
	data_t    store_data;
	data_t    store_count;
	logic     first_req_done;
	int       errors = 0;
	int       n_exp = 0;
	data_t    exp_lo [32];     // Low address byte, page is DS = 2
	data_t    exp_data [32];

	grom_cpu dut_i (
		.clk, .reset,
		.mem_req, .mem_req_valid, .mem_req_ready, .mem_rsp_valid, .mem_rdata,
		.hlt
	);

	grom_mem_model mem_i (
		.clk, .reset,
		.req(mem_req), .req_valid(mem_req_valid), .req_ready(mem_req_ready),
		.rsp_valid(mem_rsp_valid), .rdata(mem_rdata),
		.store_valid, .store_idx, .store_addr, .store_data, .store_count
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	task automatic add_expected(input data_t lo, input data_t value);
		exp_lo[n_exp[4:0]]   = lo;
		exp_data[n_exp[4:0]] = value;
		n_exp++;
	endtask

	task automatic build_expected();
		add_expected(8'h00, 8'h35 + 8'h4C);   // ADD
		add_expected(8'h01, 8'h0F ^ 8'hFF);
		add_expected(8'h02, 8'h20 - 8'h4C);   // SUB with borrow
		add_expected(8'h03, 8'hC3 & 8'h4C);
		add_expected(8'h04, 8'h12 | 8'h4C);
		add_expected(8'h05, 8'h7F + 8'h01);   // INC
		add_expected(8'h06, 8'h80 - 8'h01);   // DEC of the INC result
		add_expected(8'h07, 8'hFF);           // MOV R0,R2
		add_expected(8'h40, 8'hA7);           // Indirect STORE
		add_expected(8'h09, 8'hA7);           // Read back by indirect LOAD
		add_expected(8'h0A, 8'hA7 + 8'h01);   // Immediate LOAD then INC
		// Taken-path markers, one per jump in program order
		for (int i = 0; i < 8; i++)
			add_expected(data_t'(8'h0B + i), data_t'(8'hC1 + i));
	endtask

	always @(posedge clk)
	begin
		if (reset)
			first_req_done <= 1'b0;
		else if (mem_req_valid && mem_req_ready)
			first_req_done <= 1'b1;
	end

	reset_quiet: assert property (@(posedge clk) $past(reset) |-> !mem_req_valid && !hlt)
	else
	begin
		errors++;
		$display("[ERROR] %0t: request or halt active in reset", $time);
	end

	first_fetch: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && mem_req_ready && !first_req_done |-> mem_req.addr == '0 && !mem_req.we)
	else
	begin
		errors++;
		$display("[ERROR] %0t: first request addr %h we %b", $time, mem_req.addr, mem_req.we);
	end

	req_held: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
	else
	begin
		errors++;
		$display("[ERROR] %0t: request changed while stalled", $time);
	end

	store_in_table: assert property (@(posedge clk) disable iff (reset)
		store_valid |-> int'(store_idx) < n_exp)
	else
	begin
		errors++;
		$display("[ERROR] %0t: extra store %h to %h", $time, store_data, store_addr);
	end

	store_page: assert property (@(posedge clk) disable iff (reset)
		store_valid |-> store_addr[addr_w-1:data_w] == 4'h2)
	else
	begin
		errors++;
		$display("[ERROR] %0t: store address %h outside DS page 2", $time, store_addr);
	end

	store_value: assert property (@(posedge clk) disable iff (reset)
		store_valid && int'(store_idx) < n_exp |->
			store_addr[data_w-1:0] == exp_lo[store_idx[4:0]] &&
			store_data == exp_data[store_idx[4:0]])
	else
	begin
		errors++;
		$display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to 2%h", $time,
			store_idx, store_data, store_addr, exp_data[store_idx[4:0]], exp_lo[store_idx[4:0]]);
	end

	halt_after_stores: assert property (@(posedge clk) disable iff (reset)
		$rose(hlt) |-> int'(store_count) == n_exp)
	else
	begin
		errors++;
		$display("[ERROR] %0t: halt after %0d stores, expected %0d", $time, store_count, n_exp);
	end

	no_req_after_halt: assert property (@(posedge clk) disable iff (reset)
		hlt |-> !(mem_req_valid && mem_req_ready))
	else
	begin
		errors++;
		$display("[ERROR] %0t: request accepted after halt", $time);
	end

	initial
	begin
		#(max_cycles * clk_period);
		$display("Timeout: CPU did not halt within %0d cycles, %0d errors", max_cycles, errors);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		build_expected();
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		while (!hlt)
			@(posedge clk);
		repeat (drain_cycles) @(posedge clk);   // Quiet bus after halt
		final_count: assert (int'(store_count) == n_exp)
		else
		begin
			errors++;
			$display("[ERROR] %0t: %0d stores logged, expected %0d", $time, store_count, n_exp);
		end
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* verif/grom_mem_model.sv */
module grom_mem_model
	import grom_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  mem_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output logic     rsp_valid,
	output data_t    rdata,
	output logic     store_valid,   // One cycle per logged store
	output data_t    store_idx,
	output addr_t    store_addr,
	output data_t    store_data,
	output data_t    store_count
);

	localparam addr_t prog_end = 12'h100;   // Page 0 holds the program

	data_t mem [1 << addr_w];
	addr_t log_addr [256];
	data_t log_data [256];
	int    seed;

	initial
	begin
		seed        = 67;
		req_ready   = 1'b0;
		rsp_valid   = 1'b0;
		rdata       = '0;
		store_valid = 1'b0;
		store_idx   = '0;
		store_count = '0;
		for (int i = 0; i < (1 << addr_w); i++)
			mem[i] = data_t'(i) ^ data_t'(i >> 4);
		$readmemh("verif/program.hex", mem);
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			req_ready   <= 1'b0;
			rsp_valid   <= 1'b0;
			store_valid <= 1'b0;
			store_count <= '0;
		end
		else
		begin
			req_ready   <= ($random(seed) % 4) != 0;   // Stall about one cycle in four
			rsp_valid   <= 1'b0;
			store_valid <= 1'b0;
			if (req_valid && req_ready)
			begin
				if (!req.we)
				begin
					rsp_valid <= 1'b1;
					rdata     <= mem[req.addr];
				end
				else
				begin
					mem[req.addr] <= req.wdata;
					if (req.addr >= prog_end)
					begin
						log_addr[store_count] <= req.addr;
						log_data[store_count] <= req.wdata;
						store_idx             <= store_count;
						store_valid           <= 1'b1;
						store_count           <= store_count + 1'b1;
					end
				end
			end
		end
	end

	assign store_addr = log_addr[store_idx];
	assign store_data = log_data[store_idx];

endmodule

/* verif/program.hex */
// Instruction bytes loaded from address 000, several per line in address order
// Comment gives the start address and the instructions of the line
E0 02 F0 35 F1 4C 11 F8 00   // 00 mov ds,02; mov r0,35; mov r1,4c; add r1; st [00],r0
F0 0F F2 FF 2E F8 01         // 09 mov r0,0f; mov r2,ff; xor r2; st [01],r0
F0 20 15 F8 02               // 10 mov r0,20; sub r1; st [02],r0
F0 C3 21 F8 03               // 15 mov r0,c3; and r1; st [03],r0
F0 12 25 F8 04               // 1a mov r0,12; or r1; st [04],r0
F3 7F 33 FB 05               // 1f mov r3,7f; inc r3; st [05],r3
37 FB 06                     // 24 dec r3; st [06],r3
02 F8 07                     // 27 mov r0,r2; st [07],r0
F1 40 F2 A7 66               // 2a mov r1,40; mov r2,a7; st [r1],r2
F3 00 5D FB 09               // 2f mov r3,00; ld r3,[r1]; st [09],r3
F4 40 30 F8 0A               // 34 ld r0,[40]; inc r0; st [0a],r0
E0 05 F1 12 75               // 39 mov ds,05; mov r1,12; mov ds,r1
F3 EE F0 55 F1 55 39         // 3e mov r3,ee; mov r0,55; mov r1,55; cmp r1
F2 C1 85 4B FB 0B FA 0B      // 45 jz taken
F2 C2 86 53 FA 0C            // 4d jnz not taken
F0 10 F1 20 39               // 53 mov r0,10; mov r1,20; cmp r1
F2 C3 81 5E FB 0D FA 0D      // 58 jc taken
F2 C4 82 66 FA 0E            // 60 jnc not taken
F2 C5 83 6C FB 0F FA 0F      // 66 jm taken
25                           // 6e or r1
F2 C6 84 75 FB 10 FA 10      // 6f jp taken
F2 C7 81 7D FA 11            // 77 jc not taken, logic cleared cf
F2 C8 80 83 FB 12 FA 12      // 7d jmp
90 89 FB 13 7F               // 85 jump 089; halt
